//--- wfg_defs.svh
/* Widths, page numbers and fraction bits shared by the waveform generator blocks
   Included by every file that sizes a bus, a sample or a page compare */
`ifndef WFG_DEFS_SVH
`define WFG_DEFS_SVH

// Bus sizing
`define WFG_BUSW      32
`define WFG_ADR_W     4     // Register offset bits inside a page

// Signed two's complement samples
`define WFG_SAMPLE_W  18

// Sine coefficient is Q1.16
`define WFG_COEF_FRAC 16

// Address bits 31 to 4 select the peripheral
`define WFG_PAGE_CORE 1
`define WFG_PAGE_SINE 2
`define WFG_PAGE_SPI  3

`endif

//--- wfg_pkg.sv
/* Register offset and SPI state types of the waveform generator
   Referenced by scoped name from the peripherals */
`default_nettype none
`include "wfg_defs.svh"

package wfg_pkg;

    // Offsets inside a page, address bits 3 to 0
    typedef enum logic [`WFG_ADR_W-1:0] {
        REG_CTRL = 4'h0,
        REG_CFG0 = 4'h4,
        REG_CFG1 = 4'h8,
        REG_STAT = 4'hC
    } wfg_reg_e;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE    // One cycle to release cs_n
    } spi_state_e;

endpackage

`default_nettype wire

//--- wfg_wb_if.sv
/* Register bus from the page decoder to one peripheral
   The decoder drives the request side, the peripheral answers with ack and read data */
`default_nettype none
`include "wfg_defs.svh"

interface wfg_wb_if;
    logic                  stb;
    logic                  we;
    logic [`WFG_ADR_W-1:0] adr;     // Offset inside the page
    logic [`WFG_BUSW-1:0]  dat_wr;
    logic [`WFG_BUSW-1:0]  dat_rd;  // Combinational from adr
    logic                  ack;     // Same cycle as stb

    modport master (
        output stb, we, adr, dat_wr,
        input  dat_rd, ack
    );

    modport slave (
        input  stb, we, adr, dat_wr,
        output dat_rd, ack
    );
endinterface

`default_nettype wire

//--- wfg_core.sv
/* Pattern timing core, makes the subcycle and sync pulses for the downstream blocks
   CTRL bit 0 runs the counters, CFG0 and CFG1 set the subcycle and sync periods */
`default_nettype none
`include "wfg_defs.svh"

module wfg_core (
    input  logic    io_wbs_clk,
    input  logic    rst_n_i,
    wfg_wb_if.slave wb,
    output logic    pat_sync_o,
    output logic    pat_subcycle_o,
    output logic    active_o
);
    logic        ctrl_en;
    logic [15:0] cfg_div;   // Cycles per subcycle minus one
    logic [7:0]  cfg_subs;  // Subcycles per sync minus one
    logic [15:0] sub_cnt;
    logic [7:0]  sync_cnt;  // Subcycles left before the next sync

    assign wb.ack   = wb.stb;
    assign active_o = ctrl_en;

    always_comb begin
        case (wfg_pkg::wfg_reg_e'(wb.adr))
            wfg_pkg::REG_CTRL: wb.dat_rd = `WFG_BUSW'(ctrl_en);
            wfg_pkg::REG_CFG0: wb.dat_rd = `WFG_BUSW'(cfg_div);
            wfg_pkg::REG_CFG1: wb.dat_rd = `WFG_BUSW'(cfg_subs);
            wfg_pkg::REG_STAT: wb.dat_rd = `WFG_BUSW'({sync_cnt, ctrl_en});
            default:           wb.dat_rd = '0;
        endcase
    end

    // Register writes
    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_en  <= 1'b0;
            cfg_div  <= '0;
            cfg_subs <= '0;
        end else if (wb.stb && wb.we) begin
            case (wfg_pkg::wfg_reg_e'(wb.adr))
                wfg_pkg::REG_CTRL: ctrl_en  <= wb.dat_wr[0];
                wfg_pkg::REG_CFG0: cfg_div  <= wb.dat_wr[15:0];
                wfg_pkg::REG_CFG1: cfg_subs <= wb.dat_wr[7:0];
                default: ;
            endcase
        end
    end

    // Two chained down-counters
    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sub_cnt        <= '0;
            sync_cnt       <= '0;
            pat_subcycle_o <= 1'b0;
            pat_sync_o     <= 1'b0;
        end else if (!ctrl_en) begin
            // Preload so the first period is full length
            sub_cnt        <= cfg_div;
            sync_cnt       <= cfg_subs;
            pat_subcycle_o <= 1'b0;
            pat_sync_o     <= 1'b0;
        end else begin
            pat_subcycle_o <= (sub_cnt == '0);
            pat_sync_o     <= (sub_cnt == '0) && (sync_cnt == '0);
            if (sub_cnt == '0) begin
                sub_cnt  <= cfg_div;
                sync_cnt <= (sync_cnt == '0) ? cfg_subs : sync_cnt - 8'd1;
            end else begin
                sub_cnt <= sub_cnt - 16'd1;
            end
        end
    end

    // The SPI driver relies on sync landing on a subcycle boundary
    assert property (@(posedge io_wbs_clk) disable iff (!rst_n_i)
        pat_sync_o |-> pat_subcycle_o);

endmodule

`default_nettype wire

//--- wfg_stim_sine.sv
/* Sine stimulus, a second-order integer recurrence stepped once per stream transfer
   CFG0 holds 2*cos(step) in Q1.16, CFG1 the starting amplitude */
`default_nettype none
`include "wfg_defs.svh"

module wfg_stim_sine (
    input  logic                     io_wbs_clk,
    input  logic                     rst_n_i,
    wfg_wb_if.slave                  wb,
    input  logic                     sample_ready_i,
    output logic                     sample_valid_o,
    output logic [`WFG_SAMPLE_W-1:0] sample_data_o
);
    localparam int SW = `WFG_SAMPLE_W;
    localparam int CW = `WFG_COEF_FRAC + 2;  // Sign, one integer bit, fraction
    localparam int PW = SW + CW;

    logic                 ctrl_en;
    logic                 en_q;      // Enable one cycle late, catches the rising edge
    logic [CW-1:0]        coef;
    logic [SW-1:0]        amp;
    logic signed [SW-1:0] cur_q;
    logic signed [SW-1:0] prev_q;
    logic signed [PW-1:0] prod;
    logic signed [PW-1:0] diff;
    logic                 xfer;

    assign wb.ack = wb.stb;

    always_comb begin
        case (wfg_pkg::wfg_reg_e'(wb.adr))
            wfg_pkg::REG_CTRL: wb.dat_rd = `WFG_BUSW'(ctrl_en);
            wfg_pkg::REG_CFG0: wb.dat_rd = `WFG_BUSW'(coef);
            wfg_pkg::REG_CFG1: wb.dat_rd = `WFG_BUSW'(amp);
            wfg_pkg::REG_STAT: wb.dat_rd = `WFG_BUSW'(cur_q);  // Sign-extended
            default:           wb.dat_rd = '0;
        endcase
    end

    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_en <= 1'b0;
            coef    <= '0;
            amp     <= '0;
        end else if (wb.stb && wb.we) begin
            case (wfg_pkg::wfg_reg_e'(wb.adr))
                wfg_pkg::REG_CTRL: ctrl_en <= wb.dat_wr[0];
                wfg_pkg::REG_CFG0: coef    <= wb.dat_wr[CW-1:0];
                wfg_pkg::REG_CFG1: amp     <= wb.dat_wr[SW-1:0];
                default: ;
            endcase
        end
    end

    // Valid only once the amplitude has been loaded
    assign sample_valid_o = ctrl_en && en_q;
    assign sample_data_o  = cur_q;
    assign xfer           = sample_valid_o && sample_ready_i;

    // s[n+1] = (c * s[n]) >>> 16 - s[n-1], wrapped to the sample width
    assign prod = $signed(coef) * cur_q;
    assign diff = (prod >>> `WFG_COEF_FRAC) - prev_q;

    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q   <= 1'b0;
            cur_q  <= '0;
            prev_q <= '0;
        end else begin
            en_q <= ctrl_en;
            if (ctrl_en && !en_q) begin
                // Restart the oscillator from the programmed amplitude
                cur_q  <= $signed(amp);
                prev_q <= '0;
            end else if (xfer) begin
                prev_q <= cur_q;
                cur_q  <= diff[SW-1:0];
            end
        end
    end

    assert property (@(posedge io_wbs_clk) disable iff (!rst_n_i)
        !ctrl_en |-> !sample_valid_o);

endmodule

`default_nettype wire

//--- wfg_drive_spi.sv
/* SPI output driver, shifts one stream sample out MSB first on each pattern sync
   CFG0 sets the sclk half period, CFG1 the word length from 1 to 18 */
`default_nettype none
`include "wfg_defs.svh"

module wfg_drive_spi (
    input  logic                     io_wbs_clk,
    input  logic                     rst_n_i,
    wfg_wb_if.slave                  wb,
    input  logic                     pat_sync_i,
    input  logic                     pat_subcycle_i,
    input  logic                     sample_valid_i,
    input  logic [`WFG_SAMPLE_W-1:0] sample_data_i,
    output logic                     sample_ready_o,
    output logic                     spi_sclk_o,
    output logic                     spi_cs_n_o,
    output logic                     spi_sdo_o
);
    localparam int W = `WFG_SAMPLE_W;

    logic                ctrl_en;
    logic [15:0]         cfg_div;   // Half period minus one
    logic [4:0]          cfg_len;
    logic [4:0]          eff_len;   // Word length clamped to 1..W
    wfg_pkg::spi_state_e state;
    logic [W-1:0]        shreg;
    logic [4:0]          bit_cnt;   // Rising edges still to come
    logic [15:0]         div_cnt;
    logic                tick;
    logic                accept;
    logic [15:0]         words;

    assign wb.ack = wb.stb;

    always_comb begin
        case (wfg_pkg::wfg_reg_e'(wb.adr))
            wfg_pkg::REG_CTRL: wb.dat_rd = `WFG_BUSW'(ctrl_en);
            wfg_pkg::REG_CFG0: wb.dat_rd = `WFG_BUSW'(cfg_div);
            wfg_pkg::REG_CFG1: wb.dat_rd = `WFG_BUSW'(cfg_len);
            wfg_pkg::REG_STAT: wb.dat_rd = `WFG_BUSW'({words, state != wfg_pkg::SPI_IDLE});
            default:           wb.dat_rd = '0;
        endcase
    end

    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_en <= 1'b0;
            cfg_div <= '0;
            cfg_len <= '0;
        end else if (wb.stb && wb.we) begin
            case (wfg_pkg::wfg_reg_e'(wb.adr))
                wfg_pkg::REG_CTRL: ctrl_en <= wb.dat_wr[0];
                wfg_pkg::REG_CFG0: cfg_div <= wb.dat_wr[15:0];
                wfg_pkg::REG_CFG1: cfg_len <= wb.dat_wr[4:0];
                default: ;
            endcase
        end
    end

    assign eff_len = (cfg_len == 5'd0) ? 5'd1 : (cfg_len > 5'(W)) ? 5'(W) : cfg_len;

    // Only sync pulses seen while idle take a sample
    assign sample_ready_o = ctrl_en && (state == wfg_pkg::SPI_IDLE) && pat_sync_i;
    assign accept         = sample_ready_o && sample_valid_i;
    assign tick           = (div_cnt == '0);

    // Half-period divider, realigned to the pattern until a word starts
    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else if ((pat_subcycle_i && state != wfg_pkg::SPI_SHIFT) || tick) begin
            div_cnt <= cfg_div;
        end else begin
            div_cnt <= div_cnt - 16'd1;
        end
    end

    // Shift on each falling edge, except after the last bit
    always_ff @(posedge io_wbs_clk) begin
        if (accept) begin
            shreg <= sample_data_i;
        end else if (state == wfg_pkg::SPI_SHIFT && tick && spi_sclk_o && bit_cnt != '0) begin
            shreg <= shreg << 1;
        end
    end

    assign spi_sdo_o = (state == wfg_pkg::SPI_SHIFT) && shreg[W-1];

    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= wfg_pkg::SPI_IDLE;
            bit_cnt    <= '0;
            spi_sclk_o <= 1'b0;
            spi_cs_n_o <= 1'b1;
            words      <= '0;
        end else if (!ctrl_en) begin
            // Abort any word in flight
            state      <= wfg_pkg::SPI_IDLE;
            spi_sclk_o <= 1'b0;
            spi_cs_n_o <= 1'b1;
        end else begin
            case (state)
                wfg_pkg::SPI_IDLE: begin
                    if (accept) begin
                        state      <= wfg_pkg::SPI_SHIFT;
                        bit_cnt    <= eff_len;
                        spi_cs_n_o <= 1'b0;
                    end
                end
                wfg_pkg::SPI_SHIFT: begin
                    if (tick) begin
                        spi_sclk_o <= !spi_sclk_o;
                        if (!spi_sclk_o) begin
                            bit_cnt <= bit_cnt - 5'd1;  // Rising edge, slave samples
                        end else if (bit_cnt == '0) begin
                            state <= wfg_pkg::SPI_DONE;
                        end
                    end
                end
                wfg_pkg::SPI_DONE: begin
                    state      <= wfg_pkg::SPI_IDLE;
                    spi_cs_n_o <= 1'b1;
                    words      <= words + 16'd1;
                end
                default: state <= wfg_pkg::SPI_IDLE;
            endcase
        end
    end

    assert property (@(posedge io_wbs_clk) disable iff (!rst_n_i)
        (state == wfg_pkg::SPI_IDLE) |-> spi_cs_n_o);

    // Clock parks low whenever the slave is deselected
    assert property (@(posedge io_wbs_clk) disable iff (!rst_n_i)
        spi_cs_n_o |-> !spi_sclk_o);

endmodule

`default_nettype wire

//--- wfg_top.sv
/* Waveform generator top, decodes the bus page and routes accesses to three peripherals
   Core pulses pace the sine stream into the SPI driver */
`default_nettype none
`include "wfg_defs.svh"

module wfg_top (
    input  logic                 io_wbs_clk,
    input  logic                 rst_n_i,
    input  logic [`WFG_BUSW-1:0] io_wbs_adr_i,
    input  logic [`WFG_BUSW-1:0] io_wbs_dat_wr_i,
    input  logic                 io_wbs_we_i,
    input  logic                 io_wbs_stb_i,
    output logic [`WFG_BUSW-1:0] io_wbs_dat_rd_o,
    output logic                 io_wbs_ack_o,
    output logic                 io_wbs_err_o,
    output logic                 spi_sclk_o,
    output logic                 spi_cs_n_o,
    output logic                 spi_sdo_o,
    output logic                 active_o
);
    localparam int PGW = `WFG_BUSW - `WFG_ADR_W;

    logic [PGW-1:0] page;
    logic [2:0]     page_sel;   // Core, sine, SPI
    logic           none_sel;
    logic           stb_gate;   // Blocks the held second cycle of a strobe

    logic                     pat_sync;
    logic                     pat_subcycle;
    logic                     sample_valid;
    logic                     sample_ready;
    logic [`WFG_SAMPLE_W-1:0] sample_data;

    wfg_wb_if core_bus ();
    wfg_wb_if sine_bus ();
    wfg_wb_if spi_bus ();

    assign page        = io_wbs_adr_i[`WFG_BUSW-1:`WFG_ADR_W];
    assign page_sel[0] = (page == PGW'(`WFG_PAGE_CORE));
    assign page_sel[1] = (page == PGW'(`WFG_PAGE_SINE));
    assign page_sel[2] = (page == PGW'(`WFG_PAGE_SPI));
    assign none_sel    = ~|page_sel;
    assign stb_gate    = io_wbs_stb_i && !io_wbs_ack_o && !io_wbs_err_o;

    // Request side of each peripheral bus
    assign core_bus.stb    = stb_gate && page_sel[0];
    assign core_bus.we     = io_wbs_we_i;
    assign core_bus.adr    = io_wbs_adr_i[`WFG_ADR_W-1:0];
    assign core_bus.dat_wr = io_wbs_dat_wr_i;

    assign sine_bus.stb    = stb_gate && page_sel[1];
    assign sine_bus.we     = io_wbs_we_i;
    assign sine_bus.adr    = io_wbs_adr_i[`WFG_ADR_W-1:0];
    assign sine_bus.dat_wr = io_wbs_dat_wr_i;

    assign spi_bus.stb     = stb_gate && page_sel[2];
    assign spi_bus.we      = io_wbs_we_i;
    assign spi_bus.adr     = io_wbs_adr_i[`WFG_ADR_W-1:0];
    assign spi_bus.dat_wr  = io_wbs_dat_wr_i;

    always_ff @(posedge io_wbs_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            io_wbs_ack_o <= 1'b0;
            io_wbs_err_o <= 1'b0;
        end else begin
            io_wbs_ack_o <= core_bus.ack || sine_bus.ack || spi_bus.ack;
            io_wbs_err_o <= stb_gate && none_sel;  // Unmapped page
        end
    end

    // One-hot read mux, zero when no slave answered
    always_ff @(posedge io_wbs_clk) begin
        io_wbs_dat_rd_o <= ({`WFG_BUSW{core_bus.ack}} & core_bus.dat_rd)
                         | ({`WFG_BUSW{sine_bus.ack}} & sine_bus.dat_rd)
                         | ({`WFG_BUSW{spi_bus.ack}}  & spi_bus.dat_rd);
    end

    wfg_core u_core (
        .io_wbs_clk     (io_wbs_clk),
        .rst_n_i        (rst_n_i),
        .wb             (core_bus.slave),
        .pat_sync_o     (pat_sync),
        .pat_subcycle_o (pat_subcycle),
        .active_o       (active_o)
    );

    wfg_stim_sine u_stim_sine (
        .io_wbs_clk     (io_wbs_clk),
        .rst_n_i        (rst_n_i),
        .wb             (sine_bus.slave),
        .sample_ready_i (sample_ready),
        .sample_valid_o (sample_valid),
        .sample_data_o  (sample_data)
    );

    wfg_drive_spi u_drive_spi (
        .io_wbs_clk     (io_wbs_clk),
        .rst_n_i        (rst_n_i),
        .wb             (spi_bus.slave),
        .pat_sync_i     (pat_sync),
        .pat_subcycle_i (pat_subcycle),
        .sample_valid_i (sample_valid),
        .sample_data_i  (sample_data),
        .sample_ready_o (sample_ready),
        .spi_sclk_o     (spi_sclk_o),
        .spi_cs_n_o     (spi_cs_n_o),
        .spi_sdo_o      (spi_sdo_o)
    );

    assert property (@(posedge io_wbs_clk) disable iff (!rst_n_i)
        $onehot0(page_sel));

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
/* Free-running testbench clock, period of 10 time units */
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;  // Half period

endmodule

`default_nettype wire

//--- wfg_tb.sv
/* Testbench for the waveform generator, random register traffic and SPI word capture
   Bus reads and SPI words are checked against register and sine models kept here */
`default_nettype none
`include "wfg_defs.svh"

module wfg_tb;
    localparam int TIMEOUT = 2000;
    localparam int SW      = `WFG_SAMPLE_W;

    logic        clk;
    logic        rst_n;
    logic [31:0] adr;
    logic [31:0] dat_wr;
    logic        we;
    logic        stb;
    logic [31:0] dat_rd;
    logic        ack;
    logic        err;
    logic        sclk;
    logic        cs_n;
    logic        sdo;
    logic        active;

    logic [31:0]   model_reg [1:3][0:2];  // Page, then CTRL, CFG0, CFG1
    logic [SW-1:0] sine_cur;
    logic [SW-1:0] sine_prev;

    tb_clk_gen u_clk (.clk_o(clk));

    wfg_top UUT (
        .io_wbs_clk      (clk),
        .rst_n_i         (rst_n),
        .io_wbs_adr_i    (adr),
        .io_wbs_dat_wr_i (dat_wr),
        .io_wbs_we_i     (we),
        .io_wbs_stb_i    (stb),
        .io_wbs_dat_rd_o (dat_rd),
        .io_wbs_ack_o    (ack),
        .io_wbs_err_o    (err),
        .spi_sclk_o      (sclk),
        .spi_cs_n_o      (cs_n),
        .spi_sdo_o       (sdo),
        .active_o        (active)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Error at time %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    // Implemented bits of each register
    function automatic logic [31:0] reg_mask(input int page, input int idx);
        case (idx)
            0:       reg_mask = 32'h1;
            1:       reg_mask = (page == 2) ? 32'h3_FFFF : 32'hFFFF;
            default: reg_mask = (page == 1) ? 32'hFF : (page == 2) ? 32'h3_FFFF : 32'h1F;
        endcase
    endfunction

    // s[n+1] = (c * s[n]) >>> 16 - s[n-1], kept to the sample width
    function automatic logic [SW-1:0] sine_next(input logic [SW-1:0] c,
                                                input logic [SW-1:0] s,
                                                input logic [SW-1:0] p);
        longint cl;
        longint sl;
        longint pl;
        longint nl;
        cl = {{(64-SW){c[SW-1]}}, c};
        sl = {{(64-SW){s[SW-1]}}, s};
        pl = {{(64-SW){p[SW-1]}}, p};
        nl = ((cl * sl) >>> `WFG_COEF_FRAC) - pl;
        sine_next = nl[SW-1:0];
    endfunction

    // One access, the response must come exactly one cycle after stb
    task automatic bus_access(input logic [31:0] a, input logic w, input logic [31:0] d,
                              output logic [31:0] rd, output logic got_ack,
                              output logic got_err);
        int   cycles;
        logic done;
        adr    = a;
        we     = w;
        dat_wr = d;
        stb    = 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (ack || err) begin
                done = 1'b1;
            end else if (cycles >= TIMEOUT) begin
                fail_now("Timeout: the bus gave neither ack nor err");
            end
        end
        check_eq(32'(cycles), 32'd1, "bus response latency");
        rd      = dat_rd;
        got_ack = ack;
        got_err = err;
        stb     = 1'b0;
        @(negedge clk);  // Strobe low for a cycle before the next access
    endtask

    task automatic read_reg(input int page, input int idx, output logic [31:0] rd);
        logic g_ack;
        logic g_err;
        bus_access({page[27:0], 4'(idx * 4)}, 1'b0, 32'd0, rd, g_ack, g_err);
        check_eq({31'd0, g_ack}, 32'd1, "ack on mapped read");
        check_eq({31'd0, g_err}, 32'd0, "err on mapped read");
    endtask

    task automatic read_check(input int page, input int idx, input logic [31:0] exp,
                              input string msg);
        logic [31:0] rd;
        read_reg(page, idx, rd);
        check_eq(rd, exp, msg);
    endtask

    task automatic write_reg(input int page, input int idx, input logic [31:0] data);
        logic [31:0] rd;
        logic        g_ack;
        logic        g_err;
        bus_access({page[27:0], 4'(idx * 4)}, 1'b1, data, rd, g_ack, g_err);
        check_eq({31'd0, g_ack}, 32'd1, "ack on mapped write");
        check_eq({31'd0, g_err}, 32'd0, "err on mapped write");
        model_reg[page][idx] = data & reg_mask(page, idx);
    endtask

    task automatic check_model();
        for (int page = 1; page <= 3; page++) begin
            for (int idx = 0; idx <= 2; idx++) begin
                read_check(page, idx, model_reg[page][idx], "register against model");
            end
        end
    endtask

    // Collects one SPI word, sdo taken where sclk was seen rising
    task automatic capture_word(output logic [31:0] word, output int edges);
        int   cycles;
        logic prev_sclk;
        cycles = 0;
        while (cs_n) begin
            check_eq({31'd0, sclk}, 32'd0, "sclk while cs_n high");
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                fail_now("Timeout: cs_n never went low for the next SPI word");
            end
        end
        word      = 32'd0;
        edges     = 0;
        prev_sclk = sclk;
        cycles    = 0;
        while (!cs_n) begin
            if (sclk && !prev_sclk) begin
                word = {word[30:0], sdo};
                edges++;
            end
            prev_sclk = sclk;
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                fail_now("Timeout: cs_n stayed low, the SPI word never ended");
            end
        end
    endtask

    initial begin
        int            page;
        int            idx;
        int            len;
        int            edges;
        logic [31:0]   a;
        logic [31:0]   rd;
        logic [31:0]   word;
        logic          g_ack;
        logic          g_err;
        logic [15:0]   words_base;
        logic [SW-1:0] coef;
        logic [SW-1:0] amp;
        logic [SW-1:0] nxt;

        rst_n    = 1'b0;
        adr      = 32'd0;
        dat_wr   = 32'd0;
        we       = 1'b0;
        stb      = 1'b0;
        void'($urandom(32'hc252bc43));
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Outputs idle and every register zero out of reset
        check_eq({26'd0, ack, err, sclk, cs_n, sdo, active}, 32'h4, "outputs after reset");
        for (int p = 1; p <= 3; p++) begin
            for (int i = 0; i <= 3; i++) begin
                read_check(p, i, 32'd0, "register after reset");
            end
            for (int i = 0; i <= 2; i++) begin
                model_reg[p][i] = 32'd0;
            end
        end

        repeat (60) begin
            page = $urandom_range(3, 1);
            idx  = $urandom_range(2, 0);
            if ($urandom_range(1, 0) == 1) begin
                write_reg(page, idx, $urandom);
            end else begin
                read_check(page, idx, model_reg[page][idx], "random readback");
            end
        end

        // Unmapped pages answer with err and zero data
        repeat (20) begin
            a = $urandom;
            if (a[31:4] != 28'd0 && a[31:4] < 28'd4) begin
                a[31] = 1'b1;
            end
            bus_access(a, 1'($urandom_range(1, 0)), $urandom, rd, g_ack, g_err);
            check_eq({31'd0, g_err}, 32'd1, "err on unmapped page");
            check_eq({31'd0, g_ack}, 32'd0, "ack on unmapped page");
            check_eq(rd, 32'd0, "read data on unmapped page");
        end
        check_model();

        write_reg(1, 1, $urandom_range(7, 0));
        write_reg(1, 2, $urandom_range(3, 0));
        write_reg(1, 0, 32'd1);
        check_eq({31'd0, active}, 32'd1, "active_o after core enable");
        read_reg(1, 3, rd);
        check_eq(rd & 32'd1, 32'd1, "core STAT active bit");
        write_reg(1, 0, 32'd0);
        check_eq({31'd0, active}, 32'd0, "active_o after core disable");

        // Sine into SPI, all blocks stopped before reprogramming
        for (int p = 1; p <= 3; p++) begin
            write_reg(p, 0, 32'd0);
        end
        read_reg(3, 3, rd);
        check_eq(rd & 32'd1, 32'd0, "SPI busy while disabled");
        words_base = rd[16:1];
        coef = SW'($urandom);
        amp  = SW'($urandom);
        len  = $urandom_range(SW, 1);
        write_reg(2, 1, {14'd0, coef});
        write_reg(2, 2, {14'd0, amp});
        write_reg(3, 1, $urandom_range(3, 0));
        write_reg(3, 2, 32'(len));
        write_reg(1, 1, $urandom_range(7, 0));
        write_reg(1, 2, $urandom_range(3, 0));
        write_reg(2, 0, 32'd1);
        write_reg(3, 0, 32'd1);
        sine_cur  = amp;      // First sample is the amplitude itself
        sine_prev = '0;
        write_reg(1, 0, 32'd1);

        for (int n = 0; n < 6; n++) begin
            capture_word(word, edges);
            check_eq(32'(edges), 32'(len), "rising sclk edges per word");
            check_eq(word, 32'(sine_cur >> (SW - len)), "SPI word against sine model");
            nxt       = sine_next(coef, sine_cur, sine_prev);
            sine_prev = sine_cur;
            sine_cur  = nxt;
        end
        write_reg(3, 0, 32'd0);
        read_reg(3, 3, rd);
        check_eq(rd, {15'd0, 16'(words_base + 16'd6), 1'b0}, "SPI STAT word count");

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
wfg_pkg.sv
wfg_wb_if.sv
wfg_core.sv
wfg_stim_sine.sv
wfg_drive_spi.sv
wfg_top.sv
tb_clk_gen.sv
wfg_tb.sv

//--- run.sh
#!/bin/sh
# Builds the waveform generator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module wfg_tb -o wfg_sim

# Result is decided by the pass line in the simulation output
./obj_dir/wfg_sim | tee /dev/stderr | grep "sim passed" > /dev/null
